// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define XLEN        64
`define INST_W      32
`define REG_IDX_W   5
`define PC_START    64'h0000_0000_8000_0000

// major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_STORE   7'b0100011

`define F3_ADD_SUB  3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_SW       3'b010
`define F3_SD       3'b011
`define F7_SUB      7'b0100000

`define SIZE_WORD   2'd2
`define SIZE_DWORD  2'd3

`endif

// File: source/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`INST_W-1:0]    inst_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [1:0]            bus_size_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    // if/id payload
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_pkt_t;

    // id/ex payload, operands already forwarded
    typedef struct packed {
        alu_op_t   alu_op;
        xlen_t     op_a;
        xlen_t     op_b;
        xlen_t     st_data;
        reg_idx_t  rd_idx;
        logic      rd_en;
        logic      st_en;
        bus_size_t st_size;
    } exec_pkt_t;

    // ex/mem payload
    typedef struct packed {
        xlen_t     result;
        xlen_t     st_data;
        reg_idx_t  rd_idx;
        logic      rd_en;
        logic      st_en;
        bus_size_t st_size;
    } mem_pkt_t;

endpackage

// File: source/rd_fwd_if.sv
`timescale 1ns/1ps

// destination register result of one pipeline stage
interface rd_fwd_if;

    logic              valid;
    logic              rd_en;
    cpu_pkg::reg_idx_t rd_idx;
    cpu_pkg::xlen_t    rd_data;

    modport src (
        output valid,
        output rd_en,
        output rd_idx,
        output rd_data
    );

    modport sink (
        input valid,
        input rd_en,
        input rd_idx,
        input rd_data
    );

endinterface

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_unit (
    input  logic                mem2wb_inst_selfdefine_o,
    input  logic                reset,
    input  logic                stall_i,
    input  logic                if_ready_i,
    input  cpu_pkg::inst_t      if_data_read_i,
    output logic                if_valid_o,
    output cpu_pkg::xlen_t      if_addr_o,
    output logic                fetch_valid_o,
    output cpu_pkg::fetch_pkt_t fetch_pkt_o
);

    cpu_pkg::xlen_t pc_q;
    logic           if_fire;

    // no new request while a store holds the pipeline
    assign if_valid_o = ~stall_i;
    assign if_addr_o  = pc_q;
    assign if_fire    = if_valid_o & if_ready_i;

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            pc_q <= `PC_START;
        end else if (if_fire) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    // returned instruction goes straight into if2id
    assign fetch_valid_o = if_fire;

    always_comb begin
        fetch_pkt_o.pc   = pc_q;
        fetch_pkt_o.inst = if_data_read_i;
    end

    // request address must not move before the bus accepts it
    a_addr_stable : assert property (
        @(posedge mem2wb_inst_selfdefine_o) disable iff (reset)
        (if_valid_o && !if_ready_i) |=> $stable(if_addr_o)
    ) else $error("if_addr_o changed while waiting for if_ready_i");

endmodule

// File: source/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     mem2wb_inst_selfdefine_o,
    input  logic     reset,
    input  logic     stall_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    output payload_t out_data_o
);

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            out_valid_o <= 1'b0;
        end else if (!stall_i) begin
            out_valid_o <= in_valid_i;
        end
    end

    // payload only qualified by out_valid_o
    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (!stall_i) begin
            out_data_o <= in_data_i;
        end
    end

endmodule

// File: source/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_unit (
    input  logic                mem2wb_inst_selfdefine_o,
    input  logic                reset,
    input  logic                in_valid_i,
    input  cpu_pkg::fetch_pkt_t in_pkt_i,
    rd_fwd_if.sink              ex_fwd,
    rd_fwd_if.sink              mem_wb,
    output logic                out_valid_o,
    output cpu_pkg::exec_pkt_t  out_pkt_o
);

    cpu_pkg::xlen_t    regs [32];
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    cpu_pkg::reg_idx_t rs1_idx;
    cpu_pkg::reg_idx_t rs2_idx;
    cpu_pkg::xlen_t    rs1_val;
    cpu_pkg::xlen_t    rs2_val;
    cpu_pkg::xlen_t    imm_i;
    cpu_pkg::xlen_t    imm_s;
    cpu_pkg::xlen_t    imm_u;
    logic              ex_hit;
    logic              wb_hit;

    assign opcode  = in_pkt_i.inst[6:0];
    assign funct3  = in_pkt_i.inst[14:12];
    assign funct7  = in_pkt_i.inst[31:25];
    assign rs1_idx = in_pkt_i.inst[19:15];
    assign rs2_idx = in_pkt_i.inst[24:20];

    assign imm_i = {{52{in_pkt_i.inst[31]}}, in_pkt_i.inst[31:20]};
    assign imm_s = {{52{in_pkt_i.inst[31]}}, in_pkt_i.inst[31:25], in_pkt_i.inst[11:7]};
    assign imm_u = {{32{in_pkt_i.inst[31]}}, in_pkt_i.inst[31:12], 12'b0};

    assign ex_hit = ex_fwd.valid & ex_fwd.rd_en;
    assign wb_hit = mem_wb.valid & mem_wb.rd_en;

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_hit && mem_wb.rd_idx != '0) begin
            regs[mem_wb.rd_idx] <= mem_wb.rd_data;
        end
    end

    // youngest producer wins, x0 never forwards
    function automatic cpu_pkg::xlen_t src_value(input cpu_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (ex_hit && ex_fwd.rd_idx == idx) begin
            return ex_fwd.rd_data;
        end else if (wb_hit && mem_wb.rd_idx == idx) begin
            return mem_wb.rd_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_val = src_value(rs1_idx);
        rs2_val = src_value(rs2_idx);
    end

    assign out_valid_o = in_valid_i;

    always_comb begin
        out_pkt_o         = '0;
        out_pkt_o.alu_op  = cpu_pkg::ALU_ADD;
        out_pkt_o.op_a    = rs1_val;
        out_pkt_o.st_data = rs2_val;
        out_pkt_o.rd_idx  = in_pkt_i.inst[11:7];
        out_pkt_o.st_size = `SIZE_DWORD;
        case (opcode)
            `OPC_OP_IMM: begin
                out_pkt_o.op_b  = imm_i;
                out_pkt_o.rd_en = (funct3 == `F3_ADD_SUB);
            end
            `OPC_OP: begin
                out_pkt_o.op_b  = rs2_val;
                out_pkt_o.rd_en = (funct7 == 7'b0);
                case (funct3)
                    `F3_ADD_SUB: begin
                        if (funct7 == `F7_SUB) begin
                            out_pkt_o.alu_op = cpu_pkg::ALU_SUB;
                            out_pkt_o.rd_en  = 1'b1;
                        end
                    end
                    `F3_XOR: out_pkt_o.alu_op = cpu_pkg::ALU_XOR;
                    `F3_OR:  out_pkt_o.alu_op = cpu_pkg::ALU_OR;
                    `F3_AND: out_pkt_o.alu_op = cpu_pkg::ALU_AND;
                    // shifts and slt retire as no-ops
                    default: out_pkt_o.rd_en = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                out_pkt_o.alu_op = cpu_pkg::ALU_PASS_B;
                out_pkt_o.op_b   = imm_u;
                out_pkt_o.rd_en  = 1'b1;
            end
            `OPC_STORE: begin
                out_pkt_o.op_b  = imm_s;
                out_pkt_o.st_en = (funct3 == `F3_SW) || (funct3 == `F3_SD);
                if (funct3 == `F3_SW) begin
                    out_pkt_o.st_size = `SIZE_WORD;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic               in_valid_i,
    input  cpu_pkg::exec_pkt_t in_pkt_i,
    rd_fwd_if.src              ex_fwd,
    output logic               out_valid_o,
    output cpu_pkg::mem_pkt_t  out_pkt_o
);

    cpu_pkg::xlen_t result;

    // also forms the store address
    always_comb begin
        case (in_pkt_i.alu_op)
            cpu_pkg::ALU_ADD:    result = in_pkt_i.op_a + in_pkt_i.op_b;
            cpu_pkg::ALU_SUB:    result = in_pkt_i.op_a - in_pkt_i.op_b;
            cpu_pkg::ALU_AND:    result = in_pkt_i.op_a & in_pkt_i.op_b;
            cpu_pkg::ALU_OR:     result = in_pkt_i.op_a | in_pkt_i.op_b;
            cpu_pkg::ALU_XOR:    result = in_pkt_i.op_a ^ in_pkt_i.op_b;
            cpu_pkg::ALU_PASS_B: result = in_pkt_i.op_b;
            default:             result = '0;
        endcase
    end

    assign out_valid_o = in_valid_i;

    always_comb begin
        out_pkt_o.result  = result;
        out_pkt_o.st_data = in_pkt_i.st_data;
        out_pkt_o.rd_idx  = in_pkt_i.rd_idx;
        out_pkt_o.rd_en   = in_pkt_i.rd_en;
        out_pkt_o.st_en   = in_pkt_i.st_en;
        out_pkt_o.st_size = in_pkt_i.st_size;
    end

    // result for the instruction right behind
    assign ex_fwd.valid   = in_valid_i;
    assign ex_fwd.rd_en   = in_pkt_i.rd_en;
    assign ex_fwd.rd_idx  = in_pkt_i.rd_idx;
    assign ex_fwd.rd_data = result;

endmodule

// File: source/store_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module store_unit (
    input  logic                 in_valid_i,
    input  cpu_pkg::mem_pkt_t    in_pkt_i,
    input  logic                 cpu_mem_ready_i,
    rd_fwd_if.src                mem_wb,
    output logic                 cpu_mem_valid_o,
    output cpu_pkg::xlen_t       cpu_mem_addr_o,
    output cpu_pkg::xlen_t       cpu_mem_data_write_o,
    output cpu_pkg::bus_size_t   cpu_mem_size_o,
    output logic                 cpu_mem_req_o,
    output logic                 mem_stall_o
);

    assign cpu_mem_valid_o      = in_valid_i & in_pkt_i.st_en;
    assign cpu_mem_addr_o       = in_pkt_i.result;
    assign cpu_mem_data_write_o = in_pkt_i.st_data;
    assign cpu_mem_size_o       = in_pkt_i.st_size;
    assign cpu_mem_req_o        = in_pkt_i.st_en;

    // whole pipeline holds until the store is accepted
    assign mem_stall_o = cpu_mem_valid_o & ~cpu_mem_ready_i;

    // retire point, written into the register file at the next edge
    assign mem_wb.valid   = in_valid_i;
    assign mem_wb.rd_en   = in_pkt_i.rd_en;
    assign mem_wb.rd_idx  = in_pkt_i.rd_idx;
    assign mem_wb.rd_data = in_pkt_i.result;

    // a store never writes rd, so a stalled item never retires twice
    always_comb begin
        if (cpu_mem_valid_o) begin
            assert (!in_pkt_i.rd_en &&
                    (in_pkt_i.st_size == `SIZE_WORD || in_pkt_i.st_size == `SIZE_DWORD))
                else $error("data bus request for an item that is not a legal store");
        end
    end

endmodule

// File: source/cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu (
    input  logic               mem2wb_inst_selfdefine_o,
    input  logic               reset,
    input  logic               if_ready_i,
    input  cpu_pkg::inst_t     if_data_read_i,
    output logic               if_valid_o,
    output cpu_pkg::xlen_t     if_addr_o,
    output cpu_pkg::bus_size_t if_size_o,
    output logic               if_req_o,
    output logic               cpu_mem_valid_o,
    input  logic               cpu_mem_ready_i,
    output cpu_pkg::xlen_t     cpu_mem_data_write_o,
    output cpu_pkg::xlen_t     cpu_mem_addr_o,
    output cpu_pkg::bus_size_t cpu_mem_size_o,
    output logic               cpu_mem_req_o
);

    logic                fetch_valid;
    cpu_pkg::fetch_pkt_t fetch_pkt;
    logic                id_valid;
    cpu_pkg::fetch_pkt_t id_pkt;
    logic                dec_valid;
    cpu_pkg::exec_pkt_t  dec_pkt;
    logic                ex_valid;
    cpu_pkg::exec_pkt_t  ex_pkt;
    logic                exo_valid;
    cpu_pkg::mem_pkt_t   exo_pkt;
    logic                mem_valid;
    cpu_pkg::mem_pkt_t   mem_pkt;
    logic                mem_stall;

    rd_fwd_if ex_fwd ();
    rd_fwd_if mem_wb ();

    // word fetches, read only
    assign if_size_o = `SIZE_WORD;
    assign if_req_o  = 1'b0;

    fetch_unit u_fetch (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset(reset),
        .stall_i(mem_stall),
        .if_ready_i(if_ready_i),
        .if_data_read_i(if_data_read_i),
        .if_valid_o(if_valid_o),
        .if_addr_o(if_addr_o),
        .fetch_valid_o(fetch_valid),
        .fetch_pkt_o(fetch_pkt)
    );

    pipe_reg #(.payload_t(cpu_pkg::fetch_pkt_t)) if2id (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset(reset),
        .stall_i(mem_stall),
        .in_valid_i(fetch_valid),
        .in_data_i(fetch_pkt),
        .out_valid_o(id_valid),
        .out_data_o(id_pkt)
    );

    decode_unit u_decode (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset(reset),
        .in_valid_i(id_valid),
        .in_pkt_i(id_pkt),
        .ex_fwd(ex_fwd),
        .mem_wb(mem_wb),
        .out_valid_o(dec_valid),
        .out_pkt_o(dec_pkt)
    );

    pipe_reg #(.payload_t(cpu_pkg::exec_pkt_t)) id2ex (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset(reset),
        .stall_i(mem_stall),
        .in_valid_i(dec_valid),
        .in_data_i(dec_pkt),
        .out_valid_o(ex_valid),
        .out_data_o(ex_pkt)
    );

    exec_unit u_exec (
        .in_valid_i(ex_valid),
        .in_pkt_i(ex_pkt),
        .ex_fwd(ex_fwd),
        .out_valid_o(exo_valid),
        .out_pkt_o(exo_pkt)
    );

    pipe_reg #(.payload_t(cpu_pkg::mem_pkt_t)) ex2mem (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset(reset),
        .stall_i(mem_stall),
        .in_valid_i(exo_valid),
        .in_data_i(exo_pkt),
        .out_valid_o(mem_valid),
        .out_data_o(mem_pkt)
    );

    store_unit u_store (
        .in_valid_i(mem_valid),
        .in_pkt_i(mem_pkt),
        .cpu_mem_ready_i(cpu_mem_ready_i),
        .mem_wb(mem_wb),
        .cpu_mem_valid_o(cpu_mem_valid_o),
        .cpu_mem_addr_o(cpu_mem_addr_o),
        .cpu_mem_data_write_o(cpu_mem_data_write_o),
        .cpu_mem_size_o(cpu_mem_size_o),
        .cpu_mem_req_o(cpu_mem_req_o),
        .mem_stall_o(mem_stall)
    );

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    localparam int             TIMEOUT_CYCLES = 200;
    localparam int             DRAIN_FETCHES  = 10;
    localparam cpu_pkg::inst_t NOP            = 32'h0000_0013;

    // prog[0] sits at PC_START
    typedef struct packed {
        cpu_pkg::inst_t [5:0] prog;
        cpu_pkg::xlen_t       exp_addr;
        cpu_pkg::xlen_t       exp_data;
        cpu_pkg::bus_size_t   exp_size;
    } test_row_t;

    logic               mem2wb_inst_selfdefine_o = 1'b0;
    logic               reset = 1'b1;
    logic               if_ready_i = 1'b0;
    cpu_pkg::inst_t     if_data_read_i = NOP;
    logic               cpu_mem_ready_i = 1'b0;
    logic               if_valid_o;
    cpu_pkg::xlen_t     if_addr_o;
    cpu_pkg::bus_size_t if_size_o;
    logic               if_req_o;
    logic               cpu_mem_valid_o;
    cpu_pkg::xlen_t     cpu_mem_data_write_o;
    cpu_pkg::xlen_t     cpu_mem_addr_o;
    cpu_pkg::bus_size_t cpu_mem_size_o;
    logic               cpu_mem_req_o;

    test_row_t          rows [$];
    string              row_name [$];
    int                 cur_row = 0;
    string              cur_name = "reset";
    integer             seed = 96482;
    int                 wait_cycles;
    cpu_pkg::xlen_t     fetch_next;

    // bus monitor state
    cpu_pkg::xlen_t     exp_fetch_addr;
    int                 fetch_count;
    int                 store_count;
    cpu_pkg::xlen_t     cap_addr;
    cpu_pkg::xlen_t     cap_data;
    cpu_pkg::bus_size_t cap_size;
    logic               hold_pending;
    cpu_pkg::xlen_t     held_addr;
    cpu_pkg::xlen_t     held_data;
    cpu_pkg::bus_size_t held_size;

    cpu u_cpu (.*);

    always #20 mem2wb_inst_selfdefine_o = ~mem2wb_inst_selfdefine_o;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input string name, input cpu_pkg::xlen_t exp,
                              input cpu_pkg::xlen_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch in %s: address expected %h actual %h",
                                     name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input cpu_pkg::xlen_t exp,
                              input cpu_pkg::xlen_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch in %s: data expected %h actual %h",
                                     name, exp, act));
        end
    endtask

    task automatic check_size(input string name, input cpu_pkg::bus_size_t exp,
                              input cpu_pkg::bus_size_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch in %s: size expected %0d actual %0d",
                                     name, exp, act));
        end
    endtask

    function automatic cpu_pkg::inst_t enc_itype(input logic [2:0] f3, input int rd,
                                                 input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], `OPC_OP_IMM};
    endfunction

    function automatic cpu_pkg::inst_t enc_addi(input int rd, input int rs1, input int imm);
        return enc_itype(`F3_ADD_SUB, rd, rs1, imm);
    endfunction

    function automatic cpu_pkg::inst_t enc_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                                 input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic cpu_pkg::inst_t enc_lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], `OPC_LUI};
    endfunction

    function automatic cpu_pkg::inst_t enc_store(input logic [2:0] f3, input int rs1,
                                                 input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OPC_STORE};
    endfunction

    // instruction memory of the current row, NOPs past its end
    function automatic cpu_pkg::inst_t inst_at(input cpu_pkg::xlen_t addr);
        cpu_pkg::xlen_t word_idx;
        word_idx = (addr - `PC_START) >> 2;
        if (word_idx < 64'd6) begin
            return rows[cur_row].prog[word_idx[2:0]];
        end
        return NOP;
    endfunction

    task automatic add_row(input string name, input cpu_pkg::inst_t i0, i1, i2, i3, i4, i5,
                           input cpu_pkg::xlen_t addr, input cpu_pkg::xlen_t data,
                           input cpu_pkg::bus_size_t size);
        test_row_t row;
        row.prog     = {i5, i4, i3, i2, i1, i0};
        row.exp_addr = addr;
        row.exp_data = data;
        row.exp_size = size;
        rows.push_back(row);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        add_row("addi_sd", enc_addi(1, 0, 'h123), enc_store(`F3_SD, 0, 1, 'h40),
                NOP, NOP, NOP, NOP, 64'h40, 64'h123, `SIZE_DWORD);
        add_row("lui_sd", enc_lui(2, 'h12345), enc_store(`F3_SD, 0, 2, 8),
                NOP, NOP, NOP, NOP, 64'h8, 64'h0000_0000_1234_5000, `SIZE_DWORD);
        add_row("lui_neg_sw", enc_lui(3, 'hfffff), enc_addi(3, 3, 'h7ff),
                enc_store(`F3_SW, 0, 3, 'h10), NOP, NOP, NOP,
                64'h10, 64'hffff_ffff_ffff_f7ff, `SIZE_WORD);
        // consumer directly behind its producer
        add_row("add_fwd0", enc_addi(1, 0, 100), enc_addi(2, 0, 23),
                enc_rtype(7'b0, `F3_ADD_SUB, 3, 1, 2), enc_store(`F3_SD, 0, 3, 'h20),
                NOP, NOP, 64'h20, 64'h7b, `SIZE_DWORD);
        add_row("sub_fwd1", enc_addi(5, 0, 10), enc_addi(6, 0, 50),
                enc_rtype(`F7_SUB, `F3_ADD_SUB, 7, 5, 6), enc_addi(8, 0, 1),
                enc_store(`F3_SD, 0, 7, 'h28), NOP,
                64'h28, 64'hffff_ffff_ffff_ffd8, `SIZE_DWORD);
        add_row("and_fwd2", enc_addi(1, 0, 'hf0), enc_addi(2, 0, 'h3c),
                enc_rtype(7'b0, `F3_AND, 3, 1, 2), enc_addi(9, 0, 7), enc_addi(10, 0, 9),
                enc_store(`F3_SD, 0, 3, 'h30), 64'h30, 64'h30, `SIZE_DWORD);
        add_row("or_xor", enc_addi(1, 0, 'h555), enc_addi(2, 0, 'h0ff),
                enc_rtype(7'b0, `F3_OR, 3, 1, 2), enc_rtype(7'b0, `F3_XOR, 4, 3, 1),
                enc_store(`F3_SD, 0, 4, 'h38), NOP, 64'h38, 64'haa, `SIZE_DWORD);
        add_row("x0_ignored", enc_addi(1, 0, -1), enc_rtype(7'b0, `F3_OR, 0, 1, 1),
                enc_addi(0, 0, 'h7ff), enc_store(`F3_SD, 0, 0, 'h48), NOP, NOP,
                64'h48, 64'h0, `SIZE_DWORD);
        add_row("sw_base_reg", enc_addi(11, 0, 'h100), enc_addi(12, 0, -2),
                enc_store(`F3_SW, 11, 12, -4), NOP, NOP, NOP,
                64'hfc, 64'hffff_ffff_ffff_fffe, `SIZE_WORD);
        // slli is outside the subset
        add_row("skip_slli", enc_addi(1, 0, 7), enc_itype(3'b001, 1, 1, 4),
                enc_store(`F3_SD, 0, 1, 'h50), NOP, NOP, NOP, 64'h50, 64'h7, `SIZE_DWORD);
    endtask

    // random handshakes and the instruction memory
    always @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            fetch_next = `PC_START;
        end else if (if_valid_o && if_ready_i) begin
            fetch_next = if_addr_o + 64'd4;
        end else begin
            fetch_next = if_addr_o;
        end
        if_ready_i      <= ($random(seed) & 3) != 0;
        cpu_mem_ready_i <= ($random(seed) & 1) != 0;
        if_data_read_i  <= inst_at(fetch_next);
    end

    always @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            exp_fetch_addr <= `PC_START;
            fetch_count    <= 0;
            store_count    <= 0;
            hold_pending   <= 1'b0;
        end else begin
            if (if_valid_o && if_ready_i) begin
                check_addr(cur_name, exp_fetch_addr, if_addr_o);
                exp_fetch_addr <= exp_fetch_addr + 64'd4;
                fetch_count    <= fetch_count + 1;
            end
            if (if_valid_o && if_req_o) begin
                report_failure("instruction request is not marked as a read");
            end
            // a waiting store must not change
            if (hold_pending) begin
                if (!cpu_mem_valid_o) begin
                    report_failure("store request was withdrawn before the bus accepted it");
                end
                check_addr(cur_name, held_addr, cpu_mem_addr_o);
                check_data(cur_name, held_data, cpu_mem_data_write_o);
                check_size(cur_name, held_size, cpu_mem_size_o);
            end
            if (cpu_mem_valid_o && !cpu_mem_req_o) begin
                report_failure("data bus request is not marked as a write");
            end
            hold_pending <= cpu_mem_valid_o && !cpu_mem_ready_i;
            held_addr    <= cpu_mem_addr_o;
            held_data    <= cpu_mem_data_write_o;
            held_size    <= cpu_mem_size_o;
            if (cpu_mem_valid_o && cpu_mem_ready_i) begin
                store_count <= store_count + 1;
                cap_addr    <= cpu_mem_addr_o;
                cap_data    <= cpu_mem_data_write_o;
                cap_size    <= cpu_mem_size_o;
            end
        end
    end

    initial begin
        build_table();
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge mem2wb_inst_selfdefine_o);
            reset <= 1'b1;
            cur_row = i;
            cur_name = row_name[i];
            repeat (2) @(posedge mem2wb_inst_selfdefine_o);
            reset <= 1'b0;
            @(posedge mem2wb_inst_selfdefine_o);
            // first cycle out of reset
            if (!if_valid_o) begin
                report_failure("no instruction request in the first cycle after reset");
            end
            check_addr(cur_name, `PC_START, if_addr_o);
            check_size(cur_name, `SIZE_WORD, if_size_o);
            if (cpu_mem_valid_o) begin
                report_failure("data bus request in the first cycle after reset");
            end
            wait_cycles = 0;
            while (store_count == 0) begin
                if (wait_cycles >= TIMEOUT_CYCLES) begin
                    report_failure($sformatf("timeout waiting for the store of %s", cur_name));
                end
                @(posedge mem2wb_inst_selfdefine_o);
                wait_cycles++;
            end
            check_addr(cur_name, rows[i].exp_addr, cap_addr);
            check_data(cur_name, rows[i].exp_data, cap_data);
            check_size(cur_name, rows[i].exp_size, cap_size);
            // let the trailing NOPs through, a repeated transfer would show here
            wait_cycles = 0;
            while (fetch_count < DRAIN_FETCHES) begin
                if (wait_cycles >= TIMEOUT_CYCLES) begin
                    report_failure($sformatf("timeout waiting for fetches after %s", cur_name));
                end
                @(posedge mem2wb_inst_selfdefine_o);
                wait_cycles++;
            end
            if (store_count != 1) begin
                report_failure($sformatf("%s: store made %0d bus transfers instead of one",
                                         cur_name, store_count));
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: cpu.f
+incdir+source
source/cpu_pkg.sv
source/rd_fwd_if.sv
source/fetch_unit.sv
source/pipe_reg.sv
source/decode_unit.sv
source/exec_unit.sv
source/store_unit.sv
source/cpu.sv
tests/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o Vcpu_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "FAIL: simulation did not run to the end"
    exit 1
fi
echo "PASS"
exit 0
